// File: fpgaSynth.sv
`timescale 1ns/1ps

module fpgaSynth #(
	parameter int FifoDepth = 8,
	parameter int SclkDiv   = 4
) (
	input  logic                           MAX10_CLK2_50,
	input  logic                           arstN,
	input  logic                           cfgWe,
	input  synthPkg::cfgKindT              cfgKind,
	input  logic [synthPkg::VoiceIdxW-1:0] cfgVoice,
	input  synthPkg::cfgWordT              cfgData,
	output logic                           i2sSclk,
	output logic                           i2sLrclk,
	output logic                           i2sData
);
	import synthPkg::*;

	// Engine to register lookup
	voiceCfgIf cfgBus ();

	// Credit-controlled sample link
	logic                      sampleValid;
	logic signed [SampleW-1:0] sampleData;
	logic                      creditReturn;

	// Serializer pulls from the FIFO
	logic                      popReq;
	logic [SampleW-1:0]        popData;
	logic                      fifoEmpty;

	// ==================================================
	// Blocks
	// ==================================================

	voiceRegs regs0 (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.cfgWe         (cfgWe),
		.cfgKind       (cfgKind),
		.cfgVoice      (cfgVoice),
		.cfgData       (cfgData),
		.cfg           (cfgBus.regs)
	);

	voiceEngine #(.FifoDepth(FifoDepth)) engine0 (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.cfg           (cfgBus.engine),
		.sampleValid   (sampleValid),
		.sampleData    (sampleData),
		.creditReturn  (creditReturn)
	);

	sampleFifo #(.FifoDepth(FifoDepth)) fifo0 (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.sampleValid   (sampleValid),
		.sampleData    (sampleData),
		.creditReturn  (creditReturn),
		.popReq        (popReq),
		.popData       (popData),
		.fifoEmpty     (fifoEmpty)
	);

	i2sTransmitter #(.SclkDiv(SclkDiv)) i2sTx0 (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.popReq        (popReq),
		.popData       (popData),
		.fifoEmpty     (fifoEmpty),
		.i2sSclk       (i2sSclk),
		.i2sLrclk      (i2sLrclk),
		.i2sData       (i2sData)
	);

endmodule

// File: i2sTransmitter.sv
`timescale 1ns/1ps

module i2sTransmitter #(
	parameter int SclkDiv = 4
) (
	input  logic                         MAX10_CLK2_50,
	input  logic                         arstN,
	output logic                         popReq,
	input  logic [synthPkg::SampleW-1:0] popData,
	input  logic                         fifoEmpty,
	output logic                         i2sSclk,
	output logic                         i2sLrclk,
	output logic                         i2sData
);
	import synthPkg::*;

	localparam int DivW = SclkDiv > 1 ? $clog2(SclkDiv) : 1;
	// Left and right halves of one word
	localparam int WordBits = 2 * SampleW;
	localparam int BitW = $clog2(WordBits);

	logic [DivW-1:0]     divCnt;
	logic                divTick;
	logic                fallTick;
	logic                loadTick;
	logic [BitW-1:0]     bitCnt;
	logic [BitW-1:0]     bitNext;
	logic [SampleW-1:0]  loadSample;
	logic [WordBits-1:0] shiftReg;

	// ==================================================
	// Bit clock and word position
	// ==================================================

	assign divTick = divCnt == DivW'(SclkDiv - 1);
	// Sclk about to fall
	assign fallTick = divTick && i2sSclk;
	assign bitNext = bitCnt + 1'b1;
	// Left half starts when the bit count wraps
	assign loadTick = fallTick && (bitNext == '0);

	// Underrun sends silence
	assign popReq = loadTick && !fifoEmpty;
	assign loadSample = fifoEmpty ? '0 : popData;

	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			divCnt   <= '0;
			i2sSclk  <= 1'b0;
			i2sLrclk <= 1'b0;
			i2sData  <= 1'b0;
			// First falling edge opens a left half
			bitCnt   <= BitW'(WordBits - 1);
		end else begin
			divCnt <= divTick ? '0 : divCnt + 1'b1;
			if (divTick) begin
				i2sSclk <= ~i2sSclk;
			end
			if (fallTick) begin
				bitCnt   <= bitNext;
				// Low for left, high for right
				i2sLrclk <= bitNext[BitW-1];
				// MSB goes out with the word clock edge
				i2sData  <= loadTick ? loadSample[SampleW-1] : shiftReg[WordBits-1];
			end
		end
	end

	// ==================================================
	// Serial shifter
	// ==================================================

	// Same sample on both channels, MSB already sent
	always_ff @(posedge MAX10_CLK2_50) begin
		if (loadTick) begin
			shiftReg <= {loadSample[SampleW-2:0], loadSample, 1'b0};
		end else if (fallTick) begin
			shiftReg <= shiftReg << 1;
		end
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the synthesizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_fpgaSynth; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/Vtb_fpgaSynth)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" <<< "$output"; then
	exit 0
fi
exit 1

// File: sampleFifo.sv
`timescale 1ns/1ps

module sampleFifo #(
	parameter int FifoDepth = 8
) (
	input  logic                         MAX10_CLK2_50,
	input  logic                         arstN,
	input  logic                         sampleValid,
	input  logic [synthPkg::SampleW-1:0] sampleData,
	output logic                         creditReturn,
	input  logic                         popReq,
	output logic [synthPkg::SampleW-1:0] popData,
	output logic                         fifoEmpty
);
	import synthPkg::*;

	localparam int PtrW = FifoDepth > 1 ? $clog2(FifoDepth) : 1;
	localparam int CntW = $clog2(FifoDepth + 1);

	logic [SampleW-1:0] mem [FifoDepth];
	logic [PtrW-1:0]    wrPtr;
	logic [PtrW-1:0]    rdPtr;
	logic [CntW-1:0]    count;
	logic               pop;

	assign fifoEmpty = count == '0;
	// Requests on an empty buffer are ignored
	assign pop = popReq && !fifoEmpty;
	// Head word, no read latency
	assign popData = mem[rdPtr];

	// Storage, writes only
	always_ff @(posedge MAX10_CLK2_50) begin
		if (sampleValid) begin
			mem[wrPtr] <= sampleData;
		end
	end

	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			count        <= '0;
			creditReturn <= 1'b0;
		end else begin
			// Explicit wrap, depth need not be a power of two
			if (sampleValid) begin
				wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({sampleValid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Freed slot goes back to the engine
			creditReturn <= pop;
		end
	end

endmodule

// File: synthPkg.sv
package synthPkg;

	// ==================================================
	// Datapath widths
	// ==================================================

	// Voices sharing the one datapath
	localparam int NumVoices = 4;
	localparam int VoiceIdxW = 2;

	// Phase accumulator and increment
	localparam int PhaseW = 32;

	// Mono audio sample, signed
	localparam int SampleW = 16;

	// Unsigned gain, full scale just under one
	localparam int AmpW = 16;

	// ==================================================
	// Register encodings
	// ==================================================

	typedef enum logic [1:0] {
		WaveSaw,
		WaveSquare,
		WaveTriangle,
		WaveOff
	} waveSelT;

	// Picks how a host config word is read
	typedef enum logic {
		CfgPhase,
		CfgVoice
	} cfgKindT;

	// Waveform and gain share one control word
	typedef struct packed {
		logic [13:0]     unused;
		waveSelT         waveSel;
		logic [AmpW-1:0] amplitude;
	} voiceCtlT;

	// Same 32 bits, either a phase increment or a control word
	typedef union packed {
		logic [PhaseW-1:0] phaseIncr;
		voiceCtlT          voiceCtl;
	} cfgWordT;

endpackage

// File: tb_fpgaSynth.sv
`timescale 1ns/1ps

module tb_fpgaSynth;
	import synthPkg::*;

	localparam int FifoDepth     = 8;
	localparam int SclkDiv       = 4;
	localparam int ClkPeriod     = 8;
	localparam int ResetCycles   = 16;
	localparam int SampleTimeout = 1000;
	localparam int DiscardCount  = 2 * FifoDepth + 2;
	localparam int CheckCount    = 12;
	localparam logic [31:0] Seed = 32'h77c236a3;

	logic                 clk;
	logic                 arstN;
	logic                 cfgWe;
	cfgKindT              cfgKind;
	logic [VoiceIdxW-1:0] cfgVoice;
	cfgWordT              cfgData;
	logic                 i2sSclk;
	logic                 i2sLrclk;
	logic                 i2sData;

	int                   errorCount;
	int                   checkCount;
	logic                 timedOut;
	logic [31:0]          rngState;
	// Left words in arrival order
	logic signed [15:0]   rxQueue [$];
	logic [31:0]          rxShift;
	logic                 prevLr;
	logic                 synced;
	// Bits received since the current word began
	int                   bitPos;

	fpgaSynth #(.FifoDepth(FifoDepth), .SclkDiv(SclkDiv)) dut0 (
		.MAX10_CLK2_50 (clk),
		.arstN         (arstN),
		.cfgWe         (cfgWe),
		.cfgKind       (cfgKind),
		.cfgVoice      (cfgVoice),
		.cfgData       (cfgData),
		.i2sSclk       (i2sSclk),
		.i2sLrclk      (i2sLrclk),
		.i2sData       (i2sData)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	// ==================================================
	// I2S receiver
	// ==================================================

	// Falling lrclk ends the previous 32-bit word
	always @(posedge i2sSclk) begin
		if (prevLr && !i2sLrclk) begin
			if (synced) begin
				checkCount++;
				if (bitPos != 2 * SampleW) begin
					reportMismatch("word length in bits", bitPos, 2 * SampleW);
				end
				checkCount++;
				if (rxShift[31:16] != rxShift[15:0]) begin
					reportMismatch("right channel differs from left",
						int'(rxShift[15:0]), int'(rxShift[31:16]));
				end
				rxQueue.push_back(rxShift[31:16]);
			end
			// First partial word after reset is dropped
			synced = 1'b1;
			bitPos = 0;
		end else if (!prevLr && i2sLrclk && synced) begin
			// Right half opens right after the left sample bits
			checkCount++;
			if (bitPos != SampleW) begin
				reportMismatch("left half length in bits", bitPos, SampleW);
			end
		end
		rxShift = {rxShift[30:0], i2sData};
		bitPos++;
		prevLr = i2sLrclk;
	end

	// ==================================================
	// Helpers
	// ==================================================

	task automatic reportMismatch(input string what, input int got, input int expected);
		errorCount++;
		$display("FAILED @%0t: %s, got %0d expected %0d", $time, what, got, expected);
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Keep gain well above zero so levels stay distinct
	function automatic logic [15:0] nextAmp();
		rngState = xorshift(rngState);
		return rngState[15:0] | 16'h0100;
	endfunction

	// Waveform value times unsigned gain then arithmetic shift by 16
	function automatic int scaleWave(input int wave, input logic [15:0] amp);
		longint prod;
		prod = longint'(wave) * longint'(amp);
		return int'(prod >>> 16);
	endfunction

	task automatic writeCfg(input cfgKindT kind, input int voice, input cfgWordT data);
		@(posedge clk);
		cfgWe    <= 1'b1;
		cfgKind  <= kind;
		cfgVoice <= VoiceIdxW'(voice);
		cfgData  <= data;
		@(posedge clk);
		cfgWe    <= 1'b0;
	endtask

	task automatic setPhase(input int voice, input logic [31:0] incr);
		cfgWordT w;
		w.phaseIncr = incr;
		writeCfg(CfgPhase, voice, w);
	endtask

	task automatic setVoice(input int voice, input waveSelT wave, input logic [15:0] amp);
		cfgWordT w;
		w.voiceCtl.unused    = '0;
		w.voiceCtl.waveSel   = wave;
		w.voiceCtl.amplitude = amp;
		writeCfg(CfgVoice, voice, w);
	endtask

	// Polls the receive queue until a word arrives or the timeout hits
	task automatic waitSample(output int s);
		int waited;
		waited = 0;
		s = 0;
		while (rxQueue.size() == 0 && waited < SampleTimeout && !timedOut) begin
			@(posedge clk);
			waited++;
		end
		if (rxQueue.size() != 0) begin
			s = int'(rxQueue.pop_front());
		end else if (!timedOut) begin
			timedOut = 1'b1;
			$display("Timeout: no I2S sample arrived within %0d clock cycles", SampleTimeout);
		end
	endtask

	// Flush stale words still in the FIFO and serializer
	task automatic discardSamples();
		int s;
		rxQueue.delete();
		for (int i = 0; i < DiscardCount; i++) begin
			waitSample(s);
		end
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic silenceAfterReset();
		int s;
		discardSamples();
		for (int i = 0; i < CheckCount; i++) begin
			waitSample(s);
			checkCount++;
			if (!timedOut && s != 0) begin
				reportMismatch("silence after reset", s, 0);
			end
		end
	endtask

	task automatic singleSquareLevel();
		logic [15:0] amp;
		int          s;
		int          expected;
		amp = nextAmp();
		setPhase(0, 32'h0);
		setVoice(0, WaveSquare, amp);
		// Phase stays at zero so the square sits high
		expected = scaleWave(32767, amp);
		discardSamples();
		for (int i = 0; i < CheckCount; i++) begin
			waitSample(s);
			checkCount++;
			if (!timedOut && s != expected) begin
				reportMismatch("single square level", s, expected);
			end
		end
	endtask

	task automatic mixSaturation();
		int s;
		for (int v = 0; v < NumVoices; v++) begin
			setPhase(v, 32'h0);
			setVoice(v, WaveSquare, 16'hFFFF);
		end
		discardSamples();
		for (int i = 0; i < CheckCount; i++) begin
			waitSample(s);
			checkCount++;
			if (!timedOut && s != 32767) begin
				reportMismatch("saturated mix", s, 32767);
			end
		end
	endtask

	task automatic squareAlternation();
		logic [15:0] amp;
		int          s;
		int          prev;
		int          posVal;
		int          negVal;
		int          expected;
		amp = nextAmp();
		setVoice(0, WaveOff, 16'h0);
		setVoice(2, WaveOff, 16'h0);
		setVoice(3, WaveOff, 16'h0);
		// Half-cycle step flips the phase MSB every frame
		setPhase(1, 32'h80000000);
		setVoice(1, WaveSquare, amp);
		posVal = scaleWave(32767, amp);
		negVal = scaleWave(-32768, amp);
		discardSamples();
		waitSample(prev);
		checkCount++;
		if (!timedOut && prev != posVal && prev != negVal) begin
			reportMismatch("square level", prev, posVal);
		end
		for (int i = 0; i < CheckCount; i++) begin
			waitSample(s);
			expected = (prev == posVal) ? negVal : posVal;
			checkCount++;
			if (!timedOut && s != expected) begin
				reportMismatch("square alternation", s, expected);
			end
			prev = s;
		end
	endtask

	task automatic sawStepOrder();
		logic [15:0] amp;
		int          s;
		int          idx;
		int          sawVal;
		int          steps [4];
		amp = nextAmp();
		setVoice(1, WaveOff, 16'h0);
		setPhase(2, 32'h40000000);
		setVoice(2, WaveSaw, amp);
		// Voice 2 phase moves in quarter steps from zero
		for (int k = 0; k < 4; k++) begin
			sawVal = k * 16384;
			if (sawVal >= 32768) begin
				sawVal = sawVal - 65536;
			end
			steps[k] = scaleWave(sawVal, amp);
		end
		discardSamples();
		waitSample(s);
		idx = -1;
		for (int k = 0; k < 4; k++) begin
			if (s == steps[k]) begin
				idx = k;
			end
		end
		checkCount++;
		if (!timedOut && idx < 0) begin
			reportMismatch("first saw sample off the step grid", s, steps[0]);
			idx = 0;
		end
		for (int i = 0; i < CheckCount; i++) begin
			idx = (idx + 1) % 4;
			waitSample(s);
			checkCount++;
			if (!timedOut && s != steps[idx]) begin
				reportMismatch("saw step repeated or skipped", s, steps[idx]);
			end
		end
	endtask

	initial begin
		clk        = 1'b0;
		arstN      = 1'b0;
		cfgWe      = 1'b0;
		cfgKind    = CfgPhase;
		cfgVoice   = '0;
		cfgData    = '0;
		errorCount = 0;
		checkCount = 0;
		timedOut   = 1'b0;
		rngState   = Seed;
		rxShift    = '0;
		prevLr     = 1'b0;
		synced     = 1'b0;
		bitPos     = 0;
		repeat (ResetCycles) @(posedge clk);
		arstN <= 1'b1;

		silenceAfterReset();
		singleSquareLevel();
		mixSaturation();
		squareAlternation();
		sawStepOrder();

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timedOut);
		if (errorCount == 0 && !timedOut) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: vlog.f
synthPkg.sv
voiceCfgIf.sv
voiceRegs.sv
voiceEngine.sv
sampleFifo.sv
i2sTransmitter.sv
fpgaSynth.sv
tb_fpgaSynth.sv

// File: voiceCfgIf.sv
`timescale 1ns/1ps

interface voiceCfgIf;
	import synthPkg::*;

	// Voice currently being computed by the engine
	logic [VoiceIdxW-1:0] voiceIdx;

	// Settings of that voice, looked up combinationally
	logic [PhaseW-1:0]    phaseIncr;
	waveSelT              waveSel;
	logic [AmpW-1:0]      amplitude;

	// Engine asks by index
	modport engine (
		output voiceIdx,
		input  phaseIncr,
		input  waveSel,
		input  amplitude
	);

	// Register block answers
	modport regs (
		input  voiceIdx,
		output phaseIncr,
		output waveSel,
		output amplitude
	);

endinterface

// File: voiceEngine.sv
`timescale 1ns/1ps

module voiceEngine #(
	parameter int FifoDepth = 8
) (
	input  logic                                MAX10_CLK2_50,
	input  logic                                arstN,
	voiceCfgIf.engine                           cfg,
	output logic                                sampleValid,
	output logic signed [synthPkg::SampleW-1:0] sampleData,
	input  logic                                creditReturn
);
	import synthPkg::*;

	localparam int CreditW = $clog2(FifoDepth + 1);
	// Headroom for the sum of all voices
	localparam int AccW = SampleW + VoiceIdxW;
	localparam logic signed [SampleW-1:0] WaveMax = SampleW'(2 ** (SampleW - 1) - 1);
	localparam logic signed [SampleW-1:0] WaveMin = SampleW'(-(2 ** (SampleW - 1)));
	localparam logic signed [AccW-1:0] SatMax = AccW'(2 ** (SampleW - 1) - 1);
	localparam logic signed [AccW-1:0] SatMin = AccW'(-(2 ** (SampleW - 1)));

	logic                         running;
	logic [VoiceIdxW-1:0]         voiceIdx;
	logic                         lastVoice;
	logic [PhaseW-1:0]            phase [NumVoices];
	logic [PhaseW-1:0]            curPhase;
	logic [SampleW-2:0]           fold;
	logic signed [SampleW-1:0]    waveVal;
	logic signed [SampleW+AmpW:0] product;
	logic signed [SampleW-1:0]    scaled;
	logic signed [AccW-1:0]       acc;
	logic signed [AccW-1:0]       accNext;
	logic signed [SampleW-1:0]    mixed;
	logic [CreditW-1:0]           creditCnt;
	logic [CreditW-1:0]           creditNext;

	assign cfg.voiceIdx = voiceIdx;
	assign lastVoice = voiceIdx == VoiceIdxW'(NumVoices - 1);
	// Phase before this cycle's advance
	assign curPhase = phase[voiceIdx];

	// ==================================================
	// Waveform shaping
	// ==================================================

	// Saw folded at the MSB, rises then falls
	assign fold = curPhase[PhaseW-1] ? ~curPhase[PhaseW-2 -: SampleW-1]
		: curPhase[PhaseW-2 -: SampleW-1];

	always_comb begin
		case (cfg.waveSel)
			WaveSaw:      waveVal = curPhase[PhaseW-1 -: SampleW];
			WaveSquare:   waveVal = curPhase[PhaseW-1] ? WaveMin : WaveMax;
			// Recentre the fold around zero
			WaveTriangle: waveVal = {~fold[SampleW-2], fold[SampleW-3:0], 1'b0};
			default:      waveVal = '0;
		endcase
	end

	// Unsigned gain gets a zero sign bit
	assign product = waveVal * $signed({1'b0, cfg.amplitude});
	assign scaled = SampleW'(product >>> AmpW);
	assign accNext = acc + AccW'(scaled);

	// Clamp mix to sample range
	always_comb begin
		if (accNext > SatMax) begin
			mixed = WaveMax;
		end else if (accNext < SatMin) begin
			mixed = WaveMin;
		end else begin
			mixed = accNext[SampleW-1:0];
		end
	end

	// ==================================================
	// Credits and sequencing
	// ==================================================

	// Push and return in one cycle cancel
	always_comb begin
		creditNext = creditCnt;
		if (sampleValid && !creditReturn) begin
			creditNext = creditCnt - 1'b1;
		end else if (creditReturn && !sampleValid) begin
			creditNext = creditCnt + 1'b1;
		end
	end

	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			running     <= 1'b0;
			voiceIdx    <= '0;
			acc         <= '0;
			sampleValid <= 1'b0;
			creditCnt   <= CreditW'(FifoDepth);
			for (int v = 0; v < NumVoices; v++) begin
				phase[v] <= '0;
			end
		end else begin
			creditCnt   <= creditNext;
			sampleValid <= 1'b0;
			if (running) begin
				// One voice per cycle
				phase[voiceIdx] <= curPhase + cfg.phaseIncr;
				acc <= accNext;
				if (lastVoice) begin
					running     <= 1'b0;
					voiceIdx    <= '0;
					sampleValid <= 1'b1;
				end else begin
					voiceIdx <= voiceIdx + 1'b1;
				end
			end else if (creditNext != '0) begin
				// Idle with a credit left, next frame
				running <= 1'b1;
				acc     <= '0;
			end
		end
	end

	// Mixed sample captured on the last voice
	always_ff @(posedge MAX10_CLK2_50) begin
		if (running && lastVoice) begin
			sampleData <= mixed;
		end
	end

endmodule

// File: voiceRegs.sv
`timescale 1ns/1ps

module voiceRegs (
	input  logic                           MAX10_CLK2_50,
	input  logic                           arstN,
	input  logic                           cfgWe,
	input  synthPkg::cfgKindT              cfgKind,
	input  logic [synthPkg::VoiceIdxW-1:0] cfgVoice,
	input  synthPkg::cfgWordT              cfgData,
	voiceCfgIf.regs                        cfg
);
	import synthPkg::*;

	// ==================================================
	// Per-voice settings
	// ==================================================

	// One entry per voice
	logic [PhaseW-1:0] incrReg [NumVoices];
	waveSelT           waveReg [NumVoices];
	logic [AmpW-1:0]   ampReg  [NumVoices];

	// Host write port
	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			// Silent after reset
			for (int v = 0; v < NumVoices; v++) begin
				incrReg[v] <= '0;
				waveReg[v] <= WaveOff;
				ampReg[v]  <= '0;
			end
		end else if (cfgWe) begin
			if (cfgKind == CfgPhase) begin
				// Whole word is the increment
				incrReg[cfgVoice] <= cfgData.phaseIncr;
			end else begin
				// Control view, upper bits ignored
				waveReg[cfgVoice] <= cfgData.voiceCtl.waveSel;
				ampReg[cfgVoice]  <= cfgData.voiceCtl.amplitude;
			end
		end
	end

	// ==================================================
	// Engine read side
	// ==================================================

	// Plain mux on the engine's voice index
	assign cfg.phaseIncr = incrReg[cfg.voiceIdx];
	assign cfg.waveSel   = waveReg[cfg.voiceIdx];
	assign cfg.amplitude = ampReg[cfg.voiceIdx];

endmodule
